//--- tb.f
+incdir+logic
logic/mem_uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/nibble_packer.sv
logic/read_collector.sv
logic/mem_uart_ctrl.sv
logic/mem_uart.sv
testbench/tb_mem_uart.sv

//--- Makefile
TOP = tb_mem_uart

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1 ; cat run.log
	@if grep -q '\*\* FAIL \*\*' run.log ; then exit 1 ; fi
	@grep -q '\*\* PASS \*\*' run.log

clean:
	rm -rf obj_dir run.log

//--- testbench/tb_mem_uart.sv
/* Testbench for the memory emulator
   Host script model with its own memory, frame checks, read data checks, timeout */
`default_nettype none

`include "mem_uart_settings.svh"

module tb_mem_uart;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int AW       = `MEM_ADDR_WIDTH;
   localparam int DW       = `MEM_DATA_WIDTH;
   localparam int AN       = `MEM_ADDR_NIBBLES;
   localparam int DN       = `MEM_DATA_NIBBLES;
   localparam int BIT_CYC  = `MEM_CLKS_PER_BIT;
   localparam int NUM_RAND = 60;
   localparam int MAX_CYC  = NUM_RAND * 1200;

   // Framing commands as the host script knows them
   localparam logic [3:0] C_TRANS      = 4'b0000;
   localparam logic [3:0] C_DATA_START = 4'b0001;
   localparam logic [3:0] C_ADDR_START = 4'b0010;
   localparam logic [3:0] C_END_WRITE  = 4'b0100;
   localparam logic [3:0] C_END_READ   = 4'b1000;

   logic          i_clk = 1'b0;
   logic          i_nrst;
   logic [AW-1:0] i_addr;
   logic [DW-1:0] i_data;
   logic          i_read_valid;
   logic          i_write_valid;
   logic          i_uart_rx;
   logic [DW-1:0] o_data;
   logic          o_read_accept;
   logic          o_write_accept;
   logic          o_uart_tx;

   logic [7:0]    seen_bytes[$];
   logic [DW-1:0] host_mem[logic [AW-1:0]];
   logic [DW-1:0] exp_mem[logic [AW-1:0]];
   int            stray_count;
   int            errors;
   int            host_errors;
   int            tests_run;
   int            tests_failed;
   int            cycles = 0;

   mem_uart DUT (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_addr(i_addr), .i_data(i_data),
      .i_read_valid(i_read_valid), .i_write_valid(i_write_valid), .i_uart_rx(i_uart_rx),
      .o_data(o_data), .o_read_accept(o_read_accept), .o_write_accept(o_write_accept),
      .o_uart_tx(o_uart_tx)
   );

   always #10 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYC) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
         $display("** FAIL **");
         $finish;
      end
   end

   // Command of nibble idx in a field whose last nibble is last
   function automatic logic [3:0] frame_cmd(input int idx, input int last,
                                            input logic [3:0] start_cmd,
                                            input logic [3:0] end_cmd);
      if (idx == 0) return start_cmd;
      if (idx == last) return end_cmd;
      return C_TRANS;
   endfunction

   ////////////////////////////////////////////////////////////
   // Host script model
   ////////////////////////////////////////////////////////////

   // Samples near the middle of each bit of o_uart_tx
   task automatic host_receive(output logic [7:0] b, output logic stop_ok);
      @(negedge o_uart_tx);
      repeat (BIT_CYC / 2) @(negedge i_clk);
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CYC) @(negedge i_clk);
         b[i] = o_uart_tx;
      end
      repeat (BIT_CYC) @(negedge i_clk);
      stop_ok = o_uart_tx;
   endtask

   task automatic host_send(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge i_clk);
         #2;
         i_uart_rx = frame[i];
         repeat (BIT_CYC - 1) @(posedge i_clk);
      end
      // Two idle bits between bytes
      repeat (2 * BIT_CYC) @(posedge i_clk);
   endtask

   initial begin : host_script
      logic [7:0]    b;
      logic          stop_ok;
      logic [AW-1:0] h_addr;
      logic [DW-1:0] h_data;
      logic [DW-1:0] reply;
      logic          in_data;
      int            pos;
      i_uart_rx   = 1'b1;
      host_errors = 0;
      h_addr      = '0;
      h_data      = '0;
      in_data     = 1'b0;
      pos         = 0;
      @(posedge i_nrst);
      forever begin
         host_receive(b, stop_ok);
         seen_bytes.push_back(b);
         if (!stop_ok) begin
            $display("Stop bit low on o_uart_tx, byte %h", b);
            host_errors++;
         end
         if (b[3:0] == C_ADDR_START || b[3:0] == C_DATA_START) begin
            in_data = (b[3:0] == C_DATA_START);
            pos     = 0;
         end
         if (in_data && pos < DN) h_data[pos*4 +: 4] = b[7:4];
         else if (!in_data && pos < AN) h_addr[pos*4 +: 4] = b[7:4];
         pos++;
         if (b[3:0] == C_END_WRITE && in_data) host_mem[h_addr] = h_data;
         if (b[3:0] == C_END_READ) begin
            reply = host_mem.exists(h_addr) ? host_mem[h_addr] : '0;
            for (int i = 0; i < stray_count; i++) begin
               host_send({4'($urandom), C_TRANS});
            end
            for (int i = 0; i < DN; i++) begin
               host_send({reply[i*4 +: 4], frame_cmd(i, DN - 1, C_DATA_START, C_END_READ)});
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks and request drivers
   ////////////////////////////////////////////////////////////

   task automatic wait_accept(input string name, input logic want_write);
      forever begin
         @(negedge i_clk);
         if (want_write ? o_write_accept : o_read_accept) break;
         if (want_write ? o_read_accept : o_write_accept) begin
            $display("%s: accept pulse on the wrong port", name);
            errors++;
         end
      end
   endtask

   // An accept lasts one cycle
   task automatic check_pulse_end(input string name);
      @(negedge i_clk);
      if (o_read_accept !== 1'b0 || o_write_accept !== 1'b0) begin
         $display("%s: accept pulse lasted longer than one cycle", name);
         errors++;
      end
   endtask

   // Write accept comes as the last byte of the frame starts on the line
   task automatic check_write_timing(input string name, input int base);
      if (seen_bytes.size() - base != AN + DN - 1 || o_uart_tx !== 1'b0) begin
         $display("%s: write accept did not come at the start of the last frame byte", name);
         errors++;
      end
   endtask

   // Compares the frame starting at byte index base of the captured line
   task automatic check_frame(input string name, input logic [AW-1:0] addr,
                              input logic [DW-1:0] data, input logic is_write, input int base);
      logic [7:0] exp_b;
      int         n;
      int         j;
      n = is_write ? AN + DN : AN;
      while (seen_bytes.size() < base + n) @(negedge i_clk);
      for (int i = 0; i < n; i++) begin
         if (i < AN) begin
            exp_b = {addr[i*4 +: 4],
                     frame_cmd(i, AN - 1, C_ADDR_START, is_write ? C_END_WRITE : C_END_READ)};
         end else begin
            j     = i - AN;
            exp_b = {data[j*4 +: 4], frame_cmd(j, DN - 1, C_DATA_START, C_END_WRITE)};
         end
         if (seen_bytes[base+i] !== exp_b) begin
            $display("[ERROR] %s byte %0d: expected %h, actual %h",
                     name, i, exp_b, seen_bytes[base+i]);
            errors++;
         end
      end
   endtask

   // No extra bytes after the frame once the line has been quiet for a while
   task automatic check_quiet(input string name, input int base, input int n);
      repeat (12 * BIT_CYC) @(negedge i_clk);
      if (seen_bytes.size() - base != n) begin
         $display("[ERROR] %s byte count: expected %0d, actual %0d",
                  name, n, seen_bytes.size() - base);
         errors++;
      end
   endtask

   task automatic do_write(input string name, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data);
      int start;
      start = seen_bytes.size();
      @(posedge i_clk);
      #2;
      i_addr        = addr;
      i_data        = data;
      i_write_valid = 1'b1;
      wait_accept(name, 1'b1);
      check_write_timing(name, start);
      @(posedge i_clk);
      #2;
      i_write_valid = 1'b0;
      check_pulse_end(name);
      exp_mem[addr] = data;
      check_frame(name, addr, data, 1'b1, start);
      check_quiet(name, start, AN + DN);
   endtask

   task automatic do_read(input string name, input logic [AW-1:0] addr, input int strays);
      logic [DW-1:0] exp_d;
      logic [DW-1:0] got;
      int            start;
      exp_d       = exp_mem.exists(addr) ? exp_mem[addr] : '0;
      start       = seen_bytes.size();
      stray_count = strays;
      @(posedge i_clk);
      #2;
      i_addr       = addr;
      i_read_valid = 1'b1;
      wait_accept(name, 1'b0);
      got = o_data;
      @(posedge i_clk);
      #2;
      i_read_valid = 1'b0;
      check_pulse_end(name);
      if (got !== exp_d) begin
         $display("[ERROR] %s read %h: expected %h, actual %h", name, addr, exp_d, got);
         errors++;
      end
      check_frame(name, addr, '0, 1'b0, start);
      check_quiet(name, start, AN);
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests_run++;
      if (errors + host_errors != err_before) begin
         tests_failed++;
         $display("test %s: FAILED", name);
      end else begin
         $display("test %s: passed", name);
      end
   endtask

   initial begin : main
      logic [AW-1:0] pool[16];
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
      int            err_before;
      int            start;
      void'($urandom(54));
      i_nrst        = 1'b0;
      i_addr        = '0;
      i_data        = '0;
      i_read_valid  = 1'b0;
      i_write_valid = 1'b0;
      stray_count   = 0;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      repeat (8) @(posedge i_clk);
      #2;
      i_nrst = 1'b1;

      // Idle outputs after reset
      err_before = errors + host_errors;
      repeat (8) begin
         @(negedge i_clk);
         if (o_uart_tx !== 1'b1 || o_read_accept !== 1'b0 || o_write_accept !== 1'b0) begin
            $display("[ERROR] reset_idle tx/read/write: expected 100, actual %b%b%b",
                     o_uart_tx, o_read_accept, o_write_accept);
            errors++;
         end
      end
      if (o_data !== '0) begin
         $display("[ERROR] reset_idle o_data: expected %h, actual %h", DW'(0), o_data);
         errors++;
      end
      finish_test("reset_idle", err_before);

      err_before = errors + host_errors;
      do_write("write_frame", 16'hA5C3, 16'h5E71);
      finish_test("write_frame", err_before);

      err_before = errors + host_errors;
      do_read("read_frame", 16'hA5C3, 0);
      finish_test("read_frame", err_before);

      err_before = errors + host_errors;
      do_read("stray_reply", 16'hA5C3, 3);
      finish_test("stray_reply", err_before);

      // Pool entries 12 to 15 are only ever read
      err_before = errors + host_errors;
      foreach (pool[i]) pool[i] = AW'($urandom);
      for (int k = 0; k < NUM_RAND; k++) begin
         if ($urandom_range(0, 1) == 1) begin
            addr = pool[$urandom_range(0, 11)];
            data = DW'($urandom);
            do_write("random_mix", addr, data);
         end else begin
            do_read("random_mix", pool[$urandom_range(0, 15)], int'($urandom_range(0, 2)));
         end
      end
      finish_test("random_mix", err_before);

      // With both valids raised the write goes first and the read sees its data
      err_before  = errors + host_errors;
      addr        = 16'h0F1E;
      data        = DW'($urandom);
      start       = seen_bytes.size();
      stray_count = 0;
      @(posedge i_clk);
      #2;
      i_addr        = addr;
      i_data        = data;
      i_write_valid = 1'b1;
      i_read_valid  = 1'b1;
      wait_accept("both_valid", 1'b1);
      check_write_timing("both_valid", start);
      @(posedge i_clk);
      #2;
      i_write_valid = 1'b0;
      check_pulse_end("both_valid");
      exp_mem[addr] = data;
      wait_accept("both_valid", 1'b0);
      if (o_data !== data) begin
         $display("[ERROR] both_valid read: expected %h, actual %h", data, o_data);
         errors++;
      end
      @(posedge i_clk);
      #2;
      i_read_valid = 1'b0;
      check_pulse_end("both_valid");
      check_frame("both_valid", addr, data, 1'b1, start);
      check_frame("both_valid", addr, data, 1'b0, start + AN + DN);
      check_quiet("both_valid", start, AN + DN + AN);
      finish_test("both_valid", err_before);

      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, errors + host_errors);
      if (errors + host_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/mem_uart.sv
/* Memory emulator top level
   Design-side request port on one side, UART link to the host script on the other */
`default_nettype none

`include "mem_uart_settings.svh"

module mem_uart (
   input  wire                        i_clk,
   input  wire                        i_nrst,
   input  wire  [`MEM_ADDR_WIDTH-1:0] i_addr,
   input  wire  [`MEM_DATA_WIDTH-1:0] i_data,
   input  wire                        i_read_valid,
   input  wire                        i_write_valid,
   input  wire                        i_uart_rx,
   output wire  [`MEM_DATA_WIDTH-1:0] o_data,
   output wire                        o_read_accept,
   output wire                        o_write_accept,
   output wire                        o_uart_tx
);

   localparam int MAX_NIB = (`MEM_ADDR_NIBBLES > `MEM_DATA_NIBBLES) ?
                            `MEM_ADDR_NIBBLES : `MEM_DATA_NIBBLES;
   localparam int PTR_W   = $clog2(MAX_NIB);

   mem_uart_pkg::mem_req_t   req;
   mem_uart_pkg::uart_byte_t tx_byte;
   mem_uart_pkg::uart_byte_t rx_byte;
   wire [PTR_W-1:0]          ptr;
   wire                      data_phase;
   wire                      tx_valid;
   wire                      tx_accept;
   wire                      rx_valid;
   wire                      collect_en;
   wire                      word_done;

   mem_uart_ctrl u_ctrl (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_addr(i_addr), .i_data(i_data),
      .i_read_valid(i_read_valid), .i_write_valid(i_write_valid),
      .i_tx_accept(tx_accept), .i_word_done(word_done), .o_req(req), .o_ptr(ptr),
      .o_data_phase(data_phase), .o_tx_valid(tx_valid), .o_collect_en(collect_en),
      .o_read_accept(o_read_accept), .o_write_accept(o_write_accept)
   );

   nibble_packer u_packer (.i_req(req), .i_ptr(ptr), .i_data_phase(data_phase), .o_byte(tx_byte));

   uart_tx u_tx (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_byte(tx_byte), .i_valid(tx_valid),
      .o_accept(tx_accept), .o_tx(o_uart_tx)
   );

   uart_rx u_rx (.i_clk(i_clk), .i_nrst(i_nrst), .i_rx(i_uart_rx), .o_byte(rx_byte), .o_valid(rx_valid));

   read_collector u_collector (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_en(collect_en), .i_byte(rx_byte),
      .i_valid(rx_valid), .o_data(o_data), .o_done(word_done)
   );

endmodule

`default_nettype wire

//--- logic/mem_uart_ctrl.sv
/* Control FSM of the memory emulator
   Latches a request, steps through its frame, waits for read replies, pulses accepts */
`default_nettype none

`include "mem_uart_settings.svh"

module mem_uart_ctrl (
   input  wire                             i_clk,
   input  wire                             i_nrst,
   input  wire  [`MEM_ADDR_WIDTH-1:0]      i_addr,
   input  wire  [`MEM_DATA_WIDTH-1:0]      i_data,
   input  wire                             i_read_valid,
   input  wire                             i_write_valid,
   input  wire                             i_tx_accept,
   input  wire                             i_word_done,
   output mem_uart_pkg::mem_req_t          o_req,
   output logic [PTR_W-1:0]                o_ptr,
   output logic                            o_data_phase,
   output logic                            o_tx_valid,
   output logic                            o_collect_en,
   output logic                            o_read_accept,
   output logic                            o_write_accept
);

   localparam int MAX_NIB = (`MEM_ADDR_NIBBLES > `MEM_DATA_NIBBLES) ?
                            `MEM_ADDR_NIBBLES : `MEM_DATA_NIBBLES;
   localparam int PTR_W   = $clog2(MAX_NIB);

   mem_uart_pkg::ctrl_state_e state;
   logic                      field_last;

   assign field_last   = o_data_phase ? (o_ptr == PTR_W'(`MEM_DATA_NIBBLES - 1)) :
                                        (o_ptr == PTR_W'(`MEM_ADDR_NIBBLES - 1));
   assign o_tx_valid   = (state == mem_uart_pkg::ST_SEND) || (state == mem_uart_pkg::ST_WAIT_TX);
   assign o_collect_en = (state == mem_uart_pkg::ST_WAIT_REPLY);

   // Request is sampled every idle cycle, a write wins over a read
   always_ff @(posedge i_clk) begin
      if (state == mem_uart_pkg::ST_IDLE) begin
         o_req.addr     <= i_addr;
         o_req.data     <= i_data;
         o_req.is_write <= i_write_valid;
      end
   end

   ////////////////////////////////////////////////////////////
   // Frame sequencing
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state          <= mem_uart_pkg::ST_IDLE;
         o_ptr          <= '0;
         o_data_phase   <= 1'b0;
         o_read_accept  <= 1'b0;
         o_write_accept <= 1'b0;
      end else begin
         o_read_accept  <= 1'b0;
         o_write_accept <= 1'b0;
         case (state)
            mem_uart_pkg::ST_IDLE: begin
               o_ptr        <= '0;
               o_data_phase <= 1'b0;
               if (i_write_valid || i_read_valid) state <= mem_uart_pkg::ST_SEND;
            end
            mem_uart_pkg::ST_SEND, mem_uart_pkg::ST_WAIT_TX: begin
               if (!i_tx_accept) begin
                  state <= mem_uart_pkg::ST_WAIT_TX;
               end else if (!field_last) begin
                  o_ptr <= o_ptr + PTR_W'(1);
                  state <= mem_uart_pkg::ST_SEND;
               end else if (o_req.is_write && !o_data_phase) begin
                  // Address done, data field follows
                  o_ptr        <= '0;
                  o_data_phase <= 1'b1;
                  state        <= mem_uart_pkg::ST_SEND;
               end else if (o_req.is_write) begin
                  o_write_accept <= 1'b1;
                  state          <= mem_uart_pkg::ST_DONE;
               end else begin
                  state <= mem_uart_pkg::ST_WAIT_REPLY;
               end
            end
            mem_uart_pkg::ST_WAIT_REPLY: begin
               if (i_word_done) begin
                  o_read_accept <= 1'b1;
                  state         <= mem_uart_pkg::ST_DONE;
               end
            end
            // One cycle for the requester to drop its valid
            mem_uart_pkg::ST_DONE: state <= mem_uart_pkg::ST_IDLE;
            default: state <= mem_uart_pkg::ST_IDLE;
         endcase
      end
   end

   a_one_accept: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !(o_read_accept && o_write_accept));

endmodule

`default_nettype wire

//--- logic/read_collector.sv
/* Collects read-reply nibbles into a data word and flags a complete reply */
`default_nettype none

`include "mem_uart_settings.svh"

module read_collector (
   input  wire                             i_clk,
   input  wire                             i_nrst,
   input  wire                             i_en,
   input  mem_uart_pkg::uart_byte_t        i_byte,
   input  wire                             i_valid,
   output logic [`MEM_DATA_WIDTH-1:0]      o_data,
   output logic                            o_done
);

   localparam int POS_W = $clog2(`MEM_DATA_NIBBLES);

   logic                       started;
   logic [POS_W-1:0]           pos;
   logic [`MEM_DATA_WIDTH-1:0] word_q;
   logic [`MEM_DATA_WIDTH-1:0] merged;

   // Partial word with the incoming nibble placed at its position
   always_comb begin
      merged = word_q;
      merged[pos*4 +: 4] = i_byte.nibble;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         started <= 1'b0;
         pos     <= '0;
         o_done  <= 1'b0;
         o_data  <= '0;
      end else begin
         o_done <= 1'b0;
         if (!i_en) begin
            started <= 1'b0;
         end else if (i_valid) begin
            case (i_byte.cmd)
               mem_uart_pkg::CMD_DATA_START: begin
                  started <= 1'b1;
                  pos     <= POS_W'(1);
               end
               mem_uart_pkg::CMD_TRANS: begin
                  if (started && pos != POS_W'(`MEM_DATA_NIBBLES - 1)) pos <= pos + POS_W'(1);
                  else started <= 1'b0;
               end
               mem_uart_pkg::CMD_END_READ: begin
                  if (started && pos == POS_W'(`MEM_DATA_NIBBLES - 1)) begin
                     o_data <= merged;
                     o_done <= 1'b1;
                  end
                  started <= 1'b0;
               end
               default: started <= 1'b0;
            endcase
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_en && i_valid) begin
         if (i_byte.cmd == mem_uart_pkg::CMD_DATA_START) word_q[3:0] <= i_byte.nibble;
         else if (i_byte.cmd == mem_uart_pkg::CMD_TRANS && started) word_q <= merged;
      end
   end

   // Completion is seen by the controller while it still waits for the reply
   a_done_when_enabled: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_done |-> i_en);

endmodule

`default_nettype wire

//--- logic/nibble_packer.sv
/* Picks the outgoing nibble and its framing command for the current frame byte */
`default_nettype none

`include "mem_uart_settings.svh"

module nibble_packer (
   input  mem_uart_pkg::mem_req_t   i_req,
   input  wire [PTR_W-1:0]          i_ptr,
   input  wire                      i_data_phase,
   output mem_uart_pkg::uart_byte_t o_byte
);

   localparam int MAX_NIB = (`MEM_ADDR_NIBBLES > `MEM_DATA_NIBBLES) ?
                            `MEM_ADDR_NIBBLES : `MEM_DATA_NIBBLES;
   localparam int PTR_W   = $clog2(MAX_NIB);

   logic last_nibble;

   assign last_nibble = i_data_phase ? (i_ptr == PTR_W'(`MEM_DATA_NIBBLES - 1)) :
                                       (i_ptr == PTR_W'(`MEM_ADDR_NIBBLES - 1));

   always_comb begin
      if (i_data_phase) o_byte.nibble = i_req.data[i_ptr*4 +: 4];
      else o_byte.nibble = i_req.addr[i_ptr*4 +: 4];

      // First nibble opens the field, last one closes it with the direction
      if (i_ptr == '0) begin
         o_byte.cmd = i_data_phase ? mem_uart_pkg::CMD_DATA_START :
                                     mem_uart_pkg::CMD_ADDR_START;
      end else if (last_nibble) begin
         o_byte.cmd = i_req.is_write ? mem_uart_pkg::CMD_END_WRITE :
                                       mem_uart_pkg::CMD_END_READ;
      end else begin
         o_byte.cmd = mem_uart_pkg::CMD_TRANS;
      end
   end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
/* 8N1 UART receiver
   Two-flop line synchronizer, mid-bit sampling, one-cycle valid pulse */
`default_nettype none

`include "mem_uart_settings.svh"

module uart_rx (
   input  wire                      i_clk,
   input  wire                      i_nrst,
   input  wire                      i_rx,
   output mem_uart_pkg::uart_byte_t o_byte,
   output logic                     o_valid
);

   localparam int CNT_W = $clog2(`MEM_CLKS_PER_BIT);

   logic             rx_meta;
   logic             rx_s;
   logic             busy;
   logic             stop_ok;
   logic [CNT_W-1:0] baud_cnt;
   logic [3:0]       bit_idx;
   logic [7:0]       shift_q;
   logic             mid_bit;
   logic             end_bit;

   assign mid_bit = busy && (baud_cnt == CNT_W'(`MEM_CLKS_PER_BIT / 2));
   assign end_bit = busy && (baud_cnt == CNT_W'(`MEM_CLKS_PER_BIT - 1));
   assign o_byte  = mem_uart_pkg::uart_byte_t'(shift_q);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_s    <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_s    <= rx_meta;
      end
   end

   ////////////////////////////////////////////////////////////
   // Frame timing
   ////////////////////////////////////////////////////////////

   // The detect cycle counts as the first cycle of the start bit
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy     <= 1'b0;
         stop_ok  <= 1'b0;
         baud_cnt <= '0;
         bit_idx  <= '0;
         o_valid  <= 1'b0;
      end else begin
         o_valid <= 1'b0;
         if (!busy) begin
            if (!rx_s) begin
               busy     <= 1'b1;
               baud_cnt <= CNT_W'(1);
               bit_idx  <= '0;
            end
         end else if (mid_bit && bit_idx == 4'd0 && rx_s) begin
            // Glitch, not a real start bit
            busy <= 1'b0;
         end else begin
            if (mid_bit && bit_idx == 4'd9) stop_ok <= rx_s;
            if (end_bit) begin
               baud_cnt <= '0;
               if (bit_idx == 4'd9) begin
                  busy    <= 1'b0;
                  o_valid <= stop_ok;
               end else begin
                  bit_idx <= bit_idx + 4'd1;
               end
            end else begin
               baud_cnt <= baud_cnt + CNT_W'(1);
            end
         end
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge i_clk) begin
      if (mid_bit && bit_idx >= 4'd1 && bit_idx <= 4'd8) shift_q <= {rx_s, shift_q[7:1]};
   end

   a_valid_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_valid |=> !o_valid);

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
/* 8N1 UART transmitter with a valid/accept byte input */
`default_nettype none

`include "mem_uart_settings.svh"

module uart_tx (
   input  wire                      i_clk,
   input  wire                      i_nrst,
   input  mem_uart_pkg::uart_byte_t i_byte,
   input  wire                      i_valid,
   output logic                     o_accept,
   output logic                     o_tx
);

   localparam int CNT_W = $clog2(`MEM_CLKS_PER_BIT);

   logic             busy;
   logic [CNT_W-1:0] baud_cnt;
   logic [3:0]       bit_idx;
   logic [9:0]       shift_q;

   // A byte is taken only while the line is idle
   assign o_accept = i_valid && !busy;
   assign o_tx     = busy ? shift_q[0] : 1'b1;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy     <= 1'b0;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end else if (o_accept) begin
         busy     <= 1'b1;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end else if (busy) begin
         if (baud_cnt == CNT_W'(`MEM_CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            if (bit_idx == 4'd9) busy <= 1'b0;
            else bit_idx <= bit_idx + 4'd1;
         end else begin
            baud_cnt <= baud_cnt + CNT_W'(1);
         end
      end
   end

   // Frame is stop, data LSB first, start
   always_ff @(posedge i_clk) begin
      if (o_accept) shift_q <= {1'b1, i_byte, 1'b0};
      else if (busy && baud_cnt == CNT_W'(`MEM_CLKS_PER_BIT - 1)) shift_q <= {1'b1, shift_q[9:1]};
   end

   // No second byte is taken during a whole 10-bit frame
   a_no_accept_in_frame: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_accept |=> !o_accept [*10*`MEM_CLKS_PER_BIT]);

endmodule

`default_nettype wire

//--- logic/mem_uart_pkg.sv
/* Types for the memory emulator
   Framing commands, controller states, request and UART byte layouts */
`default_nettype none

`include "mem_uart_settings.svh"

package mem_uart_pkg;

   // Framing command in the low half of every UART byte
   typedef enum logic [3:0] {
      CMD_TRANS      = 4'b0000,
      CMD_DATA_START = 4'b0001,
      CMD_ADDR_START = 4'b0010,
      CMD_END_WRITE  = 4'b0100,
      CMD_END_READ   = 4'b1000
   } uart_cmd_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SEND,
      ST_WAIT_TX,
      ST_WAIT_REPLY,
      ST_DONE
   } ctrl_state_e;

   typedef struct packed {
      logic [`MEM_ADDR_WIDTH-1:0] addr;
      logic [`MEM_DATA_WIDTH-1:0] data;
      logic                       is_write;
   } mem_req_t;

   // Nibble in bits 7:4, command in bits 3:0
   typedef struct packed {
      logic [3:0] nibble;
      uart_cmd_e  cmd;
   } uart_byte_t;

endpackage

`default_nettype wire

//--- logic/mem_uart_settings.svh
/* Word widths and UART bit timing shared by the memory emulator */
`ifndef MEM_UART_SETTINGS_SVH
`define MEM_UART_SETTINGS_SVH

// Design-side word sizes
`define MEM_DATA_WIDTH   16
`define MEM_ADDR_WIDTH   16

// Each UART byte carries one nibble of a field
`define MEM_DATA_NIBBLES 4
`define MEM_ADDR_NIBBLES 4

// Clock cycles per UART bit
// 8 keeps simulation short, a 9600 baud link needs the real divider
`define MEM_CLKS_PER_BIT 8

`endif
